//--- source/tile_pkg.sv
// Tile package with widths, address map, opcodes and message types for the memory tile
package tile_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int TAG_W  = 4;
  localparam int DEV_W  = 4;
  localparam int DID_W  = 8;
  localparam int CORD_W = 8;

  // Device ID sits in addr[23:20], register index in addr[5:3]
  localparam int DEV_LSB     = 20;
  localparam int REG_IDX_LSB = 3;
  localparam int REG_IDX_W   = 3;

  localparam logic [ADDR_W-1:0] DRAM_BASE   = 32'h8000_0000;
  localparam logic [DEV_W-1:0]  CFG_DEV     = 4'd1;
  localparam logic [DEV_W-1:0]  SCRATCH_DEV = 4'd2;

  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01
  } mem_op_e;

  typedef enum logic [REG_IDX_W-1:0] {
    REG_FREEZE  = 3'd0,
    REG_SCRATCH = 3'd1,
    REG_DID     = 3'd2,
    REG_CORD    = 3'd3
  } cfg_reg_e;

  typedef struct packed {
    mem_op_e           op;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_cmd_s;

  // Response keeps op, tag and addr of its command
  typedef struct packed {
    mem_op_e           op;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_resp_s;

  typedef struct packed {
    logic cfg;
    logic scratch;
    logic loop;
  } dev_sel_s;

endpackage

//--- source/msg_fifo.sv
// Two-entry ready/valid FIFO with registered storage, generic over the payload type
module msg_fifo
  import tile_pkg::*;
#(
  parameter type payload_t = mem_cmd_s
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     ready_i
);

  localparam int FIFO_DEPTH = 2;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  payload_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign v_o     = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = v_i & ready_o;
  assign pop     = v_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

//--- source/mem_cmd_router.sv
// Command router that decodes the address map and steers each command to one device
module mem_cmd_router
  import tile_pkg::*;
(
  input  mem_cmd_s cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_cmd_s dev_cmd_o,
  output dev_sel_s dev_v_o,
  input  dev_sel_s dev_ready_i
);

  logic [DEV_W-1:0] dev_id;
  logic             is_local;
  logic             is_cfg;
  logic             is_scratch;
  logic             is_loop;
  logic             all_ready;
  logic             fire;

  assign dev_id   = cmd_i.addr[DEV_LSB +: DEV_W];
  assign is_local = (cmd_i.addr < DRAM_BASE);

  // DRAM space is always served by the scratch memory
  assign is_cfg     = is_local & (dev_id == CFG_DEV);
  assign is_scratch = ~is_local | (dev_id == SCRATCH_DEV);
  assign is_loop    = is_local & ~is_cfg & ~is_scratch;

  // Stall unless every device can take a command
  assign all_ready   = dev_ready_i.cfg & dev_ready_i.scratch & dev_ready_i.loop;
  assign cmd_ready_o = all_ready;
  assign fire        = cmd_v_i & all_ready;

  assign dev_v_o.cfg     = fire & is_cfg;
  assign dev_v_o.scratch = fire & is_scratch;
  assign dev_v_o.loop    = fire & is_loop;

  // Same payload goes to every device
  assign dev_cmd_o = cmd_i;

endmodule

//--- source/cfg_regs.sv
// Configuration register device with freeze and scratch registers plus read-only identity
module cfg_regs
  import tile_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [DID_W-1:0]  my_did_i,
  input  logic [CORD_W-1:0] my_cord_i,
  input  mem_cmd_s          cmd_i,
  input  logic              cmd_v_i,
  output logic              cmd_ready_o,
  output mem_resp_s         resp_o,
  output logic              resp_v_o,
  input  logic              resp_yumi_i
);

  logic              freeze_q;
  logic [DATA_W-1:0] scratch_q;
  mem_resp_s         resp_q;
  logic              resp_v_q;
  logic              accept;
  logic              is_write;
  cfg_reg_e          reg_idx;
  logic [DATA_W-1:0] rd_data;

  assign accept   = cmd_v_i & cmd_ready_o;
  assign is_write = (cmd_i.op == OP_WRITE);
  assign reg_idx  = cfg_reg_e'(cmd_i.addr[REG_IDX_LSB +: REG_IDX_W]);

  always_comb begin
    case (reg_idx)
      REG_FREEZE:  rd_data = DATA_W'(freeze_q);
      REG_SCRATCH: rd_data = scratch_q;
      REG_DID:     rd_data = DATA_W'(my_did_i);
      REG_CORD:    rd_data = DATA_W'(my_cord_i);
      default:     rd_data = '0;
    endcase
  end

  // Identity registers ignore writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      freeze_q  <= 1'b1;
      scratch_q <= '0;
    end else if (accept && is_write) begin
      if (reg_idx == REG_FREEZE)  freeze_q  <= cmd_i.data[0];
      if (reg_idx == REG_SCRATCH) scratch_q <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.op   <= cmd_i.op;
      resp_q.tag  <= cmd_i.tag;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_write ? cmd_i.data : rd_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (accept) begin
      resp_v_q <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_q <= 1'b0;
    end
  end

  assign cmd_ready_o = ~resp_v_q;
  assign resp_o      = resp_q;
  assign resp_v_o    = resp_v_q;

endmodule

//--- source/scratch_mem.sv
// Word-addressed scratch memory device standing in for the L2 cache
module scratch_mem
  import tile_pkg::*;
#(
  parameter int MEM_WORDS = 16
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  mem_cmd_s  cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_o,
  output mem_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_yumi_i
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  mem_resp_s         resp_q;
  logic              resp_v_q;
  logic              accept;
  logic              is_write;
  logic [IDX_W-1:0]  word_idx;

  assign accept   = cmd_v_i & cmd_ready_o;
  assign is_write = (cmd_i.op == OP_WRITE);

  // 8-byte words with the upper address bits aliased
  assign word_idx = cmd_i.addr[3 +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (accept && is_write) begin
      mem_q[word_idx] <= cmd_i.data;
    end
  end

  // Write responses echo the stored data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.op   <= cmd_i.op;
      resp_q.tag  <= cmd_i.tag;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_write ? cmd_i.data : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (accept) begin
      resp_v_q <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_q <= 1'b0;
    end
  end

  assign cmd_ready_o = ~resp_v_q;
  assign resp_o      = resp_q;
  assign resp_v_o    = resp_v_q;

endmodule

//--- source/loopback_dev.sv
// Loopback device answering unmapped local addresses with zero reads and echoed writes
module loopback_dev
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  mem_cmd_s  cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_o,
  output mem_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_yumi_i
);

  mem_resp_s resp_q;
  logic      resp_v_q;
  logic      accept;

  assign accept = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q.op   <= cmd_i.op;
      resp_q.tag  <= cmd_i.tag;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= (cmd_i.op == OP_WRITE) ? cmd_i.data : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (accept) begin
      resp_v_q <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_q <= 1'b0;
    end
  end

  assign cmd_ready_o = ~resp_v_q;
  assign resp_o      = resp_q;
  assign resp_v_o    = resp_v_q;

endmodule

//--- source/resp_arbiter.sv
// Fixed-priority response arbiter merging cache, cfg and loopback responses
module resp_arbiter
  import tile_pkg::*;
(
  input  mem_resp_s cache_resp_i,
  input  mem_resp_s cfg_resp_i,
  input  mem_resp_s loop_resp_i,
  input  dev_sel_s  valid_i,
  output dev_sel_s  yumi_o,
  output mem_resp_s resp_o,
  output logic      resp_v_o,
  input  logic      resp_ready_i
);

  dev_sel_s grant;

  // Cache first, then cfg, loopback last
  always_comb begin
    grant         = '0;
    grant.scratch = valid_i.scratch;
    grant.cfg     = valid_i.cfg & ~valid_i.scratch;
    grant.loop    = valid_i.loop & ~valid_i.cfg & ~valid_i.scratch;
  end

  always_comb begin
    if (grant.scratch) begin
      resp_o = cache_resp_i;
    end else if (grant.cfg) begin
      resp_o = cfg_resp_i;
    end else begin
      resp_o = loop_resp_i;
    end
  end

  assign resp_v_o = valid_i.cfg | valid_i.scratch | valid_i.loop;

  // Yumi only on an actual transfer
  assign yumi_o.scratch = grant.scratch & resp_ready_i;
  assign yumi_o.cfg     = grant.cfg & resp_ready_i;
  assign yumi_o.loop    = grant.loop & resp_ready_i;

endmodule

//--- source/mem_tile.sv
// Memory-side tile endpoint connecting command buffer, router, devices, arbiter and response buffer
module mem_tile
  import tile_pkg::*;
#(
  parameter int MEM_WORDS = 16
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [DID_W-1:0]  my_did_i,
  input  logic [CORD_W-1:0] my_cord_i,
  input  mem_cmd_s          cmd_i,
  input  logic              cmd_v_i,
  output logic              cmd_ready_o,
  output mem_resp_s         resp_o,
  output logic              resp_v_o,
  input  logic              resp_ready_i
);

  mem_cmd_s  fifo_cmd;
  logic      fifo_cmd_v;
  logic      fifo_cmd_ready;
  mem_cmd_s  dev_cmd;
  dev_sel_s  dev_v;
  dev_sel_s  dev_ready;
  logic      cfg_ready, scratch_ready, loop_ready;
  mem_resp_s cfg_resp, scratch_resp, loop_resp;
  logic      cfg_resp_v, scratch_resp_v, loop_resp_v;
  dev_sel_s  resp_v;
  dev_sel_s  resp_yumi;
  mem_resp_s arb_resp;
  logic      arb_resp_v;
  logic      arb_resp_ready;

  assign dev_ready = '{cfg: cfg_ready, scratch: scratch_ready, loop: loop_ready};
  assign resp_v    = '{cfg: cfg_resp_v, scratch: scratch_resp_v, loop: loop_resp_v};

  msg_fifo #(.payload_t(mem_cmd_s)) cmd_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(cmd_i), .v_i(cmd_v_i), .ready_o(cmd_ready_o),
    .data_o(fifo_cmd), .v_o(fifo_cmd_v), .ready_i(fifo_cmd_ready)
  );

  mem_cmd_router router (
    .cmd_i(fifo_cmd), .cmd_v_i(fifo_cmd_v), .cmd_ready_o(fifo_cmd_ready),
    .dev_cmd_o(dev_cmd), .dev_v_o(dev_v), .dev_ready_i(dev_ready)
  );

  cfg_regs cfg (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .my_did_i(my_did_i), .my_cord_i(my_cord_i),
    .cmd_i(dev_cmd), .cmd_v_i(dev_v.cfg), .cmd_ready_o(cfg_ready),
    .resp_o(cfg_resp), .resp_v_o(cfg_resp_v), .resp_yumi_i(resp_yumi.cfg)
  );

  scratch_mem #(.MEM_WORDS(MEM_WORDS)) scratch (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_i(dev_cmd), .cmd_v_i(dev_v.scratch), .cmd_ready_o(scratch_ready),
    .resp_o(scratch_resp), .resp_v_o(scratch_resp_v), .resp_yumi_i(resp_yumi.scratch)
  );

  loopback_dev loopback (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_i(dev_cmd), .cmd_v_i(dev_v.loop), .cmd_ready_o(loop_ready),
    .resp_o(loop_resp), .resp_v_o(loop_resp_v), .resp_yumi_i(resp_yumi.loop)
  );

  resp_arbiter arbiter (
    .cache_resp_i(scratch_resp), .cfg_resp_i(cfg_resp), .loop_resp_i(loop_resp),
    .valid_i(resp_v), .yumi_o(resp_yumi),
    .resp_o(arb_resp), .resp_v_o(arb_resp_v), .resp_ready_i(arb_resp_ready)
  );

  msg_fifo #(.payload_t(mem_resp_s)) resp_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .data_i(arb_resp), .v_i(arb_resp_v), .ready_o(arb_resp_ready),
    .data_o(resp_o), .v_o(resp_v_o), .ready_i(resp_ready_i)
  );

endmodule

//--- sim/mem_tile_checker.sv
// Bound assertions on the memory tile response port and router device selects
module mem_tile_checker
  import tile_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input mem_resp_s resp_i,
  input logic      resp_v_i,
  input logic      resp_ready_i,
  input logic [2:0] dev_v_i
);

  // Stalled response must hold
  resp_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_i && !resp_ready_i) |=> (resp_v_i && $stable(resp_i))
  ) else $error("resp_v_o or resp_o changed while the output was stalled");

  // First cycle out of reset
  reset_quiet_a: assert property (
    @(posedge clk_i)
    $rose(rst_n_i) |-> !resp_v_i
  ) else $error("resp_v_o high in the cycle after reset release");

  dev_onehot_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(dev_v_i)
  ) else $error("router selected more than one device");

endmodule

bind mem_tile mem_tile_checker handshake_chk (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .resp_i(resp_o),
  .resp_v_i(resp_v_o),
  .resp_ready_i(resp_ready_i),
  .dev_v_i(dev_v)
);

//--- sim/tb_mem_tile.sv
// Testbench for the memory tile with directed tests against a reference model
module tb_mem_tile
  import tile_pkg::*;
();

  localparam int MEM_WORDS  = 16;
  // Well above the few hundred cycles that the five tests take
  localparam int MAX_CYCLES = 3000;
  localparam logic [DID_W-1:0]  TB_DID    = 8'h5a;
  localparam logic [CORD_W-1:0] TB_CORD   = 8'h3c;
  localparam logic [ADDR_W-1:0] CFG_BASE  = 32'h0010_0000;
  localparam logic [ADDR_W-1:0] SCR_LOCAL = 32'h0020_0000;
  localparam logic [ADDR_W-1:0] LOOP_BASE = 32'h0070_0000;
  localparam int DEV_CFG  = 0;
  localparam int DEV_SCR  = 1;
  localparam int DEV_LOOP = 2;

  logic      clk_i;
  logic      rst_n_i;
  mem_cmd_s  cmd_i;
  logic      cmd_v_i;
  logic      cmd_ready_o;
  mem_resp_s resp_o;
  logic      resp_v_o;
  logic      resp_ready_i;

  int               seed;
  int               errors;
  int               cycles = 0;
  int               resp_count;
  logic [TAG_W-1:0] next_tag;
  mem_cmd_s         pend_q[$];
  mem_resp_s        exp_q[$];
  int               exp_dev_q[$];

  // Reference model state
  logic [DATA_W-1:0] model_mem [MEM_WORDS];
  logic              model_freeze;
  logic [DATA_W-1:0] model_scratch;

  mem_tile #(.MEM_WORDS(MEM_WORDS)) uut (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .my_did_i(TB_DID), .my_cord_i(TB_CORD),
    .cmd_i(cmd_i), .cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles, responses still missing", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic int dev_of(input logic [ADDR_W-1:0] addr);
    if (addr >= DRAM_BASE) return DEV_SCR;
    if (addr[23:20] == CFG_DEV) return DEV_CFG;
    if (addr[23:20] == SCRATCH_DEV) return DEV_SCR;
    return DEV_LOOP;
  endfunction

  function automatic logic [ADDR_W-1:0] cfg_addr(input int idx);
    return CFG_BASE + ADDR_W'(idx * 8);
  endfunction

  function automatic logic [ADDR_W-1:0] scratch_addr(input int w, input bit dram);
    return (dram ? DRAM_BASE : SCR_LOCAL) + ADDR_W'(w * 8);
  endfunction

  task automatic queue_cmd(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    mem_cmd_s c;
    c.op   = op;
    c.tag  = next_tag;
    c.addr = addr;
    c.data = data;
    pend_q.push_back(c);
    next_tag = next_tag + 1'b1;
  endtask

  // Expected response computed when the tile accepts the command
  task automatic model_accept(input mem_cmd_s c);
    mem_resp_s r;
    int        dev;
    int        idx;
    dev    = dev_of(c.addr);
    r.op   = c.op;
    r.tag  = c.tag;
    r.addr = c.addr;
    r.data = (c.op == OP_WRITE) ? c.data : '0;
    if (dev == DEV_CFG) begin
      idx = int'(c.addr[5:3]);
      if (c.op == OP_WRITE) begin
        if (idx == 0) model_freeze = c.data[0];
        if (idx == 1) model_scratch = c.data;
      end else begin
        case (idx)
          0: r.data = {63'd0, model_freeze};
          1: r.data = model_scratch;
          2: r.data = {56'd0, TB_DID};
          3: r.data = {56'd0, TB_CORD};
          default: r.data = '0;
        endcase
      end
    end else if (dev == DEV_SCR) begin
      idx = int'((c.addr >> 3) % MEM_WORDS);
      if (c.op == OP_WRITE) model_mem[idx] = c.data;
      else r.data = model_mem[idx];
    end
    exp_q.push_back(r);
    exp_dev_q.push_back(dev);
  endtask

  task automatic check_resp(input mem_resp_s r);
    int hit;
    int j;
    hit = -1;
    resp_count++;
    foreach (exp_q[i]) begin
      if (hit < 0 && exp_q[i].tag == r.tag) hit = i;
    end
    if (hit < 0) begin
      errors++;
      $display("Unexpected response with tag %0d at time %0t", r.tag, $time);
    end else begin
      for (j = 0; j < hit; j++) begin
        if (exp_dev_q[j] == exp_dev_q[hit]) begin
          errors++;
          $display("CHECK FAILED at %0t: tag %0d overtook tag %0d of the same device",
                   $time, r.tag, exp_q[j].tag);
        end
      end
      if (r !== exp_q[hit]) begin
        errors++;
        $display("CHECK FAILED at %0t: tag %0d got op %0d addr %h data %h", $time,
                 r.tag, r.op, r.addr, r.data);
        $display("  expected op %0d addr %h data %h", exp_q[hit].op, exp_q[hit].addr,
                 exp_q[hit].data);
      end
      exp_q.delete(hit);
      exp_dev_q.delete(hit);
    end
  endtask

  // Sample handshakes at the edge and drive 2 units later
  task automatic step_cycle(input int stall_pct, input bit hold);
    int roll;
    @(posedge clk_i);
    if (cmd_v_i && cmd_ready_o) model_accept(pend_q.pop_front());
    if (resp_v_o && resp_ready_i) check_resp(resp_o);
    roll = ($random(seed) & 32'h7fff_ffff) % 100;
    #2;
    cmd_v_i = (pend_q.size() != 0);
    if (pend_q.size() != 0) cmd_i = pend_q[0];
    resp_ready_i = !hold && (roll >= stall_pct);
  endtask

  task automatic run_to_completion(input int stall_pct);
    while (pend_q.size() != 0 || exp_q.size() != 0) begin
      step_cycle(stall_pct, 1'b0);
    end
  endtask

  task automatic read_reset_values();
    $display("Test: reset values of the cfg registers");
    queue_cmd(OP_READ, cfg_addr(0), '0);
    queue_cmd(OP_READ, cfg_addr(1), '0);
    queue_cmd(OP_READ, cfg_addr(2), '0);
    queue_cmd(OP_READ, cfg_addr(3), '0);
    queue_cmd(OP_READ, cfg_addr(5), '0);
    queue_cmd(OP_WRITE, cfg_addr(2), {$random(seed), $random(seed)});
    queue_cmd(OP_READ, cfg_addr(2), '0);
    run_to_completion(0);
  endtask

  task automatic write_read_scratch();
    int w;
    $display("Test: scratch memory writes and reads");
    for (w = 0; w < 8; w++) begin
      queue_cmd(OP_WRITE, scratch_addr(w, w % 2 == 0), {$random(seed), $random(seed)});
    end
    // Overwrite one word before the reads
    queue_cmd(OP_WRITE, scratch_addr(3, 1'b1), {$random(seed), $random(seed)});
    for (w = 0; w < 8; w++) begin
      queue_cmd(OP_READ, scratch_addr(w, w % 2 != 0), '0);
    end
    run_to_completion(0);
  endtask

  task automatic loopback_echo();
    int i;
    $display("Test: loopback reads and writes");
    for (i = 0; i < 4; i++) begin
      queue_cmd(OP_READ, LOOP_BASE + ADDR_W'(i * 8 + i * 4096), '0);
    end
    queue_cmd(OP_WRITE, LOOP_BASE + 32'h40, {$random(seed), $random(seed)});
    queue_cmd(OP_WRITE, LOOP_BASE + 32'h1_0008, {$random(seed), $random(seed)});
    run_to_completion(0);
  endtask

  task automatic response_backpressure();
    int start_count;
    int wait_cycles;
    bit fell;
    $display("Test: back-pressure on the response port");
    start_count = resp_count;
    queue_cmd(OP_WRITE, scratch_addr(0, 1'b1), {$random(seed), $random(seed)});
    queue_cmd(OP_READ, scratch_addr(0, 1'b0), '0);
    queue_cmd(OP_WRITE, LOOP_BASE + 32'h18, {$random(seed), $random(seed)});
    queue_cmd(OP_READ, cfg_addr(1), '0);
    queue_cmd(OP_WRITE, scratch_addr(5, 1'b0), {$random(seed), $random(seed)});
    queue_cmd(OP_READ, scratch_addr(5, 1'b1), '0);
    fell = 1'b0;
    wait_cycles = 0;
    while (!fell && wait_cycles < 40) begin
      step_cycle(0, 1'b1);
      if (!cmd_ready_o) fell = 1'b1;
      wait_cycles++;
    end
    if (!fell) begin
      errors++;
      $display("cmd_ready_o never fell while responses were blocked");
    end
    run_to_completion(0);
    if (resp_count - start_count != 6) begin
      errors++;
      $display("CHECK FAILED at %0t: %0d responses after back-pressure, expected 6",
               $time, resp_count - start_count);
    end
  endtask

  task automatic mixed_traffic();
    int      i;
    int      pick;
    int      word;
    int      start_count;
    mem_op_e op;
    $display("Test: mixed traffic with response stalls");
    start_count = resp_count;
    for (i = 0; i < 20; i++) begin
      pick = ($random(seed) & 32'h7fff_ffff) % 3;
      word = $random(seed) & 7;
      op   = ($random(seed) & 1) ? OP_WRITE : OP_READ;
      case (pick)
        0: queue_cmd(op, (op == OP_WRITE) ? cfg_addr(1) : cfg_addr(word % 6),
                     {$random(seed), $random(seed)});
        1: queue_cmd(op, scratch_addr(word, word[0]), {$random(seed), $random(seed)});
        default: queue_cmd(op, LOOP_BASE + ADDR_W'(word * 8), {$random(seed), $random(seed)});
      endcase
    end
    run_to_completion(30);
    if (resp_count - start_count != 20) begin
      errors++;
      $display("CHECK FAILED at %0t: %0d responses in mixed traffic, expected 20",
               $time, resp_count - start_count);
    end
  endtask

  initial begin
    cmd_i         = '0;
    cmd_v_i       = 1'b0;
    resp_ready_i  = 1'b0;
    rst_n_i       = 1'b0;
    seed          = 32'h4768;
    errors        = 0;
    resp_count    = 0;
    next_tag      = '0;
    model_freeze  = 1'b1;
    model_scratch = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i      = 1'b1;
    resp_ready_i = 1'b1;
    @(posedge clk_i);
    #2;
    if (cmd_ready_o !== 1'b1 || resp_v_o !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: after reset cmd_ready_o=%b resp_v_o=%b", $time,
               cmd_ready_o, resp_v_o);
    end
    read_reset_values();
    write_read_scratch();
    loopback_echo();
    response_backpressure();
    mixed_traffic();
    $display("Summary: %0d responses checked, %0d errors", resp_count, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sources.f
source/tile_pkg.sv
source/msg_fifo.sv
source/mem_cmd_router.sv
source/cfg_regs.sv
source/scratch_mem.sv
source/loopback_dev.sv
source/resp_arbiter.sv
source/mem_tile.sv
sim/mem_tile_checker.sv
sim/tb_mem_tile.sv

//--- Makefile
SIM_LOG  ?= sim.log
TOP      ?= tb_mem_tile
VFLAGS   ?= --binary --assert -Wno-fatal
OBJ_DIR  ?= obj_dir
FILELIST ?= sources.f

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	@grep -qx "No errors" $(SIM_LOG) || { echo "Simulation failed, see $(SIM_LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
